// ==== fmrt_mem_cfg.svh ====
// Word, address, register and SPM sizes, strobe and read/write encodings
`ifndef FMRT_MEM_CFG_SVH
`define FMRT_MEM_CFG_SVH

////////////////////////////////////////////////////////////
// Data path sizes
////////////////////////////////////////////////////////////
`define WORD_W          32                       // Data word width
`define BYTE_OFFSET_W   2                        // Byte lane bits below the word address
`define WORD_ADDR_W     (`WORD_W - `BYTE_OFFSET_W) // Word address width, 30
`define REG_ADDR_W      5                        // GPR index width

////////////////////////////////////////////////////////////
// Scratchpad
////////////////////////////////////////////////////////////
`define SPM_ADDR_W      10                       // SPM index width
`define SPM_DEPTH       (1 << `SPM_ADDR_W)       // 1024 words

////////////////////////////////////////////////////////////
// Bus strobe levels
////////////////////////////////////////////////////////////
`define ENABLE_         1'b0                     // Active low asserted
`define DISABLE_        1'b1                     // Active low idle
`define READ            1'b1                     // rw level for a read
`define WRITE           1'b0                     // rw level for a write

// All-zero byte offset means the access is word aligned
`define BYTE_OFFSET_ALIGNED {`BYTE_OFFSET_W{1'b0}}

`endif

// ==== fmrt_mem_pkg.sv ====
// Width typedefs, memory-op and exception enums, pipeline and bus record structs
`include "fmrt_mem_cfg.svh"

package fmrt_mem_pkg;

    typedef logic [`WORD_W-1:0]      word_t;      // Data word
    typedef logic [`WORD_ADDR_W-1:0] word_addr_t; // Byte address without lane bits
    typedef logic [`REG_ADDR_W-1:0]  reg_addr_t;  // GPR index
    typedef logic [`SPM_ADDR_W-1:0]  spm_index_t; // SPM row

    typedef enum logic [1:0] {
        MEM_OP_NOP = 2'h0,                        // No memory access
        MEM_OP_LDW = 2'h1,                        // Word load
        MEM_OP_STW = 2'h2                         // Word store
    } mem_op_t;

    typedef enum logic [2:0] {
        EXP_NONE       = 3'h0,                    // No exception
        EXP_EXT_INT    = 3'h1,                    // External interrupt
        EXP_UNDEF_INSN = 3'h2,                    // Undefined instruction
        EXP_OVERFLOW   = 3'h3,                    // Arithmetic overflow
        EXP_MISS_ALIGN = 3'h4,                    // Misaligned access
        EXP_TRAP       = 3'h5                     // Trap instruction
    } exp_code_t;

    // Record handed over by EX
    typedef struct packed {
        logic       en;                           // Valid record
        exp_code_t  exp_code;                     // Exception raised upstream
        word_t      pc;                           // Instruction address
        mem_op_t    mem_op;                       // Memory operation
        word_t      mem_wr_data;                  // Store data
        reg_addr_t  rd_addr;                      // Destination GPR
        logic       gpr_we_;                      // GPR write enable, active low
        word_t      out;                          // EX result or byte address
    } ex_mem_t;

    // Record handed to WB
    typedef struct packed {
        logic       en;                           // Valid record
        exp_code_t  exp_code;                     // Final exception code
        word_t      pc;                           // Instruction address
        reg_addr_t  rd_addr;                      // Destination GPR
        logic       gpr_we_;                      // GPR write enable, active low
        word_t      out;                          // Value for writeback
    } mem_wb_t;

    // One word access, used on both sides of bus_if
    typedef struct packed {
        word_addr_t addr;                         // Word address
        logic       as_;                          // Address strobe, active low
        logic       rw;                           // 1 read, 0 write
        word_t      wr_data;                      // Store data
    } mem_bus_req_t;

endpackage

// ==== mem_ctrl.sv ====
// Memory op decode, word alignment check, bus request build and result select
`timescale 1ns/10ps
`include "fmrt_mem_cfg.svh"

module mem_ctrl
    import fmrt_mem_pkg::*;
(
    input  ex_mem_t      ex,                      // EX/MEM record
    input  word_t        rd_data,                 // Read data back from the bus
    output mem_bus_req_t cpu_req,                 // Request towards bus_if
    output word_t        result,                  // Access result, also forwarded
    output logic         miss_align               // Misaligned word access
);

    ////////////////////////////////////////////////////////////
    // Address split
    ////////////////////////////////////////////////////////////
    logic [`BYTE_OFFSET_W-1:0] byte_offset;       // Low lane bits of the byte address
    logic                      aligned;           // Offset is zero

    assign byte_offset = ex.out[`BYTE_OFFSET_W-1:0];
    assign aligned     = (byte_offset == `BYTE_OFFSET_ALIGNED);

    ////////////////////////////////////////////////////////////
    // Decode and select
    ////////////////////////////////////////////////////////////
    always_comb begin
        // Idle request unless a valid aligned load or store is seen
        cpu_req.addr    = ex.out[`WORD_W-1:`BYTE_OFFSET_W]; // Drop the lane bits
        cpu_req.as_     = `DISABLE_;
        cpu_req.rw      = `READ;
        cpu_req.wr_data = ex.mem_wr_data;
        result          = ex.out;                 // ALU result by default
        miss_align      = 1'b0;

        if (ex.en) begin
            case (ex.mem_op)
                MEM_OP_LDW: begin
                    if (aligned) begin
                        cpu_req.as_ = `ENABLE_;   // Read strobe
                        result      = rd_data;    // Loaded word
                    end else begin
                        miss_align  = 1'b1;       // No strobe
                        result      = '0;
                    end
                end
                MEM_OP_STW: begin
                    if (aligned) begin
                        cpu_req.as_ = `ENABLE_;   // Write strobe
                        cpu_req.rw  = `WRITE;
                    end else begin
                        miss_align  = 1'b1;       // Store dropped
                        result      = '0;
                    end
                end
                default: begin
                    // NOP keeps the EX result
                end
            endcase
        end
    end

endmodule

// ==== bus_if.sv ====
// Stall and flush gating of the CPU request towards the SPM, read data return
`timescale 1ns/10ps
`include "fmrt_mem_cfg.svh"

module bus_if
    import fmrt_mem_pkg::*;
(
    ////////////////////////////////////////////////////////////
    // Pipeline control
    ////////////////////////////////////////////////////////////
    input  logic         stall,                   // Hold the stage
    input  logic         flush,                   // Kill the stage
    ////////////////////////////////////////////////////////////
    // CPU side
    ////////////////////////////////////////////////////////////
    input  mem_bus_req_t cpu_req,                 // Request from mem_ctrl
    output word_t        rd_data,                 // Read data to mem_ctrl
    ////////////////////////////////////////////////////////////
    // SPM side
    ////////////////////////////////////////////////////////////
    input  word_t        spm_rd_data,             // Read data from the SPM
    output mem_bus_req_t spm_req                  // Gated request to the SPM
);

    logic access_block;                           // Stage may not touch memory

    // Either level blocks the access, flush needs no separate priority here
    assign access_block = stall | flush;

    always_comb begin
        spm_req = cpu_req;                        // Address, rw and data pass straight
        if (access_block) begin
            spm_req.as_ = `DISABLE_;              // Drop the strobe
        end
    end

    // The SPM read is combinational and always valid for the presented address
    assign rd_data = spm_rd_data;

endmodule

// ==== spm.sv ====
// Word-wide scratchpad RAM with combinational read and clocked write
`timescale 1ns/10ps
`include "fmrt_mem_cfg.svh"

module spm
    import fmrt_mem_pkg::*;
(
    input  logic         clk,                     // Clock
    input  mem_bus_req_t spm_req,                 // Gated word request
    output word_t        spm_rd_data              // Read data
);

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////
    word_t      mem [0:`SPM_DEPTH-1];             // 1024 words, no reset
    spm_index_t index;                            // Row select
    logic       wr_en;                            // Write this edge

    // Upper word address bits alias onto the same rows
    assign index = spm_req.addr[`SPM_ADDR_W-1:0];

    assign wr_en = (spm_req.as_ == `ENABLE_) &&
                   (spm_req.rw == `WRITE);        // Strobed write only

    ////////////////////////////////////////////////////////////
    // Access
    ////////////////////////////////////////////////////////////
    assign spm_rd_data = mem[index];              // Asynchronous read

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[index] <= spm_req.wr_data;        // Visible to the next cycle
        end
    end

endmodule

// ==== mem_reg.sv ====
// MEM/WB pipeline register with stall hold, flush bubble and misalignment exception
`timescale 1ns/10ps
`include "fmrt_mem_cfg.svh"

module mem_reg
    import fmrt_mem_pkg::*;
(
    input  logic    clk,                          // Clock
    input  logic    reset,                        // Synchronous reset, active high
    input  logic    stall,                        // Hold wb
    input  logic    flush,                        // Load the bubble
    input  ex_mem_t ex,                           // EX/MEM record
    input  word_t   result,                       // Access result from mem_ctrl
    input  logic    miss_align,                   // Misaligned word access
    output mem_wb_t wb                            // MEM/WB record
);

    // Empty slot seen by WB after reset, flush or an invalid record
    localparam mem_wb_t BUBBLE = '{
        en       : 1'b0,
        exp_code : EXP_NONE,
        pc       : '0,
        rd_addr  : '0,
        gpr_we_  : `DISABLE_,
        out      : '0
    };

    ////////////////////////////////////////////////////////////
    // Register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            wb <= BUBBLE;
        end else if (flush) begin
            wb <= BUBBLE;                         // Wins over stall
        end else if (!stall) begin
            if (!ex.en) begin
                wb <= BUBBLE;                     // Nothing valid upstream
            end else begin
                wb.en      <= ex.en;
                wb.pc      <= ex.pc;
                wb.rd_addr <= ex.rd_addr;
                if (miss_align) begin
                    wb.exp_code <= EXP_MISS_ALIGN; // Replaces any upstream code
                    wb.gpr_we_  <= `DISABLE_;     // No register update
                    wb.out      <= '0;
                end else begin
                    wb.exp_code <= ex.exp_code;   // Upstream exception passes
                    wb.gpr_we_  <= ex.gpr_we_;
                    wb.out      <= result;        // Load data or EX result
                end
            end
        end
        // Stall alone keeps wb as it is
    end

endmodule

// ==== mem_stage.sv ====
// Memory access stage top: mem_ctrl, bus_if, spm and mem_reg
`timescale 1ns/10ps

module mem_stage
    import fmrt_mem_pkg::*;
(
    input  logic    clk,                          // Clock
    input  logic    reset,                        // Synchronous reset, active high
    input  logic    stall,                        // Pipeline stall
    input  logic    flush,                        // Pipeline flush
    input  ex_mem_t ex,                           // EX/MEM record
    output mem_wb_t wb,                           // MEM/WB record
    output word_t   fwd_data                      // Same-cycle result for forwarding
);

    ////////////////////////////////////////////////////////////
    // Internal nets
    ////////////////////////////////////////////////////////////
    mem_bus_req_t cpu_req;                        // Ungated request
    mem_bus_req_t spm_req;                        // Request after stall and flush gating
    word_t        rd_data;                        // Read data to mem_ctrl
    word_t        spm_rd_data;                    // Read data out of the SPM
    word_t        result;                         // Access result
    logic         miss_align;                     // Misaligned access flag

    assign fwd_data = result;

    mem_ctrl mem_ctrl0 (
        .ex          (ex),
        .rd_data     (rd_data),
        .cpu_req     (cpu_req),
        .result      (result),
        .miss_align  (miss_align)
    );

    bus_if bus_if0 (
        .stall       (stall),
        .flush       (flush),
        .cpu_req     (cpu_req),
        .rd_data     (rd_data),
        .spm_rd_data (spm_rd_data),
        .spm_req     (spm_req)
    );

    spm spm0 (
        .clk         (clk),
        .spm_req     (spm_req),
        .spm_rd_data (spm_rd_data)
    );

    mem_reg mem_reg0 (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .flush       (flush),
        .ex          (ex),
        .result      (result),
        .miss_align  (miss_align),
        .wb          (wb)
    );

endmodule

// ==== mem_stage_asserts.sv ====
// Concurrent assertions on SPM strobe gating and MEM/WB bubble and exception insertion
`timescale 1ns/10ps
`include "fmrt_mem_cfg.svh"

module mem_stage_asserts
    import fmrt_mem_pkg::*;
(
    input logic         clk,                      // Stage clock
    input logic         reset,                    // Synchronous reset
    input logic         stall,                    // Pipeline stall
    input logic         flush,                    // Pipeline flush
    input mem_bus_req_t spm_req,                  // Gated SPM request
    input logic         miss_align,               // From mem_ctrl
    input mem_wb_t      wb                        // MEM/WB record
);

    int assert_errors = 0;                        // Failed assertions so far

    ////////////////////////////////////////////////////////////
    // Access gating
    ////////////////////////////////////////////////////////////
    strobe_blocked : assert property (@(posedge clk)
        (stall || flush) |-> (spm_req.as_ == `DISABLE_))
        else begin
            assert_errors++;
            $error("SPM strobe active while stall or flush is set");
        end

    ////////////////////////////////////////////////////////////
    // MEM/WB register
    ////////////////////////////////////////////////////////////
    bubble_after_kill : assert property (@(posedge clk)
        (reset || flush) |=> !wb.en)              // Reset or flush empties wb
        else begin
            assert_errors++;
            $error("wb.en set in the cycle after reset or flush");
        end

    miss_align_code : assert property (@(posedge clk)
        (miss_align && !stall && !flush && !reset) |=> (wb.exp_code == EXP_MISS_ALIGN))
        else begin
            assert_errors++;
            $error("misaligned access not reported as EXP_MISS_ALIGN");
        end

endmodule

// Attach to every mem_stage, internal nets included
bind mem_stage mem_stage_asserts asserts0 (
    .clk        (clk),
    .reset      (reset),
    .stall      (stall),
    .flush      (flush),
    .spm_req    (spm_req),
    .miss_align (miss_align),
    .wb         (wb)
);

// ==== tb_mem_stage.sv ====
// Table-driven testbench for mem_stage: clock, reset, LCG, SPM model, compare tasks, timeout
`timescale 1ns/10ps
`include "fmrt_mem_cfg.svh"

module tb_mem_stage
    import fmrt_mem_pkg::*;
;

    localparam int RESET_CYCLES = 5;              // Reset held this long
    localparam int SLACK_CYCLES = 20;             // Margin on top of the table

    logic    clk;
    logic    reset;
    logic    stall;
    logic    flush;
    ex_mem_t ex;
    mem_wb_t wb;
    word_t   fwd_data;

    ////////////////////////////////////////////////////////////
    // Stimulus table, reference state and counters
    ////////////////////////////////////////////////////////////
    string   tbl_name  [$];                       // Test names
    ex_mem_t tbl_ex    [$];                       // Record applied
    logic    tbl_stall [$];
    logic    tbl_flush [$];
    word_t   tbl_fwd   [$];                       // Expected fwd_data, same cycle
    mem_wb_t tbl_wb    [$];                       // Expected wb, one cycle later

    word_t   model [0:`SPM_DEPTH-1];              // Reference SPM contents
    mem_wb_t wb_state;                            // Reference MEM/WB register
    word_t   pc_next     = 32'h0000_1000;         // Distinct pc per entry
    word_t   lcg_state   = 32'hd36f;              // LCG seed
    int      wb_errors   = 0;
    int      word_errors = 0;
    int      cycle_cnt   = 0;
    int      max_cycles  = 0;                     // Set once the table is built

    mem_stage dut0 (
        .clk      (clk),
        .reset    (reset),
        .stall    (stall),
        .flush    (flush),
        .ex       (ex),
        .wb       (wb),
        .fwd_data (fwd_data)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;                        // 100 ns period

    // Watchdog on the total run length
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("run timed out after %0d cycles before the table finished", cycle_cnt);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////
    function automatic word_t next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223; // Numerical Recipes constants
        return lcg_state;
    endfunction

    function automatic mem_wb_t bubble_wb();
        mem_wb_t b;
        b          = '0;
        b.exp_code = EXP_NONE;
        b.gpr_we_  = 1'b1;                        // No register write
        return b;
    endfunction

    // Appends one entry and works out its expected responses from the stage rules
    task automatic add_entry(input string name, input logic en, input mem_op_t op,
                             input word_t addr, input word_t data, input reg_addr_t rd,
                             input logic we_, input exp_code_t exp,
                             input logic st, input logic fl);
        ex_mem_t    e;
        word_addr_t wa;
        spm_index_t idx;
        logic       mem_acc;
        logic       mis;
        word_t      fwd;
        mem_wb_t    nwb;
        begin
            e             = '0;
            e.en          = en;
            e.exp_code    = exp;
            e.mem_op      = op;
            e.mem_wr_data = data;
            e.rd_addr     = rd;
            e.gpr_we_     = we_;
            e.out         = addr;                 // Byte address or ALU result
            e.pc          = pc_next;
            pc_next = pc_next + 32'd4;
            wa      = e.out[`WORD_W-1:`BYTE_OFFSET_W];
            idx     = wa[`SPM_ADDR_W-1:0];        // High bits alias
            mem_acc = e.en && (e.mem_op == MEM_OP_LDW || e.mem_op == MEM_OP_STW);
            mis     = mem_acc && (e.out[1:0] != 2'b00);
            // Same-cycle forwarded result
            if (!mem_acc)
                fwd = e.out;
            else if (mis)
                fwd = '0;
            else if (e.mem_op == MEM_OP_LDW)
                fwd = model[idx];                 // Old contents, combinational read
            else
                fwd = e.out;
            // Next MEM/WB value, flush over stall
            if (fl) begin
                nwb = bubble_wb();
            end else if (st) begin
                nwb = wb_state;                   // Held
            end else if (!e.en) begin
                nwb = bubble_wb();
            end else begin
                nwb         = '0;
                nwb.en      = 1'b1;
                nwb.pc      = e.pc;
                nwb.rd_addr = e.rd_addr;
                nwb.exp_code = mis ? EXP_MISS_ALIGN : e.exp_code;
                nwb.gpr_we_ = mis ? 1'b1 : e.gpr_we_;
                nwb.out     = mis ? '0 : fwd;
            end
            // Only an unblocked aligned store reaches the SPM
            if (mem_acc && !mis && e.mem_op == MEM_OP_STW && !st && !fl)
                model[idx] = e.mem_wr_data;
            wb_state = nwb;
            tbl_name.push_back(name);
            tbl_ex.push_back(e);
            tbl_stall.push_back(st);
            tbl_flush.push_back(fl);
            tbl_fwd.push_back(fwd);
            tbl_wb.push_back(nwb);
        end
    endtask

    task automatic build_table();
        word_t d0;
        word_t d1;
        word_t d2;
        word_t d3;
        word_t ra;
        word_t rd;
        int    k;
        begin
            d0 = next_rand();
            d1 = next_rand();
            d2 = next_rand();
            d3 = next_rand();
            wb_state = bubble_wb();               // State right after reset
            // Store then load, including an aliased address
            add_entry("st_a", 1, MEM_OP_STW, 32'h100, d0, 5'd0, 1, EXP_NONE, 0, 0);
            add_entry("ld_a", 1, MEM_OP_LDW, 32'h100, '0, 5'd3, 0, EXP_NONE, 0, 0);
            add_entry("st_b_alias", 1, MEM_OP_STW, 32'h1204, d1, 5'd0, 1, EXP_NONE, 0, 0);
            add_entry("ld_b", 1, MEM_OP_LDW, 32'h204, '0, 5'd4, 0, EXP_NONE, 0, 0);
            // Misaligned accesses write nothing
            add_entry("st_mis", 1, MEM_OP_STW, 32'h102, d2, 5'd0, 1, EXP_NONE, 0, 0);
            add_entry("ld_mis", 1, MEM_OP_LDW, 32'h101, '0, 5'd5, 0, EXP_NONE, 0, 0);
            add_entry("ld_a_after_mis", 1, MEM_OP_LDW, 32'h100, '0, 5'd6, 0, EXP_NONE, 0, 0);
            // Non-memory records pass through
            add_entry("nop", 1, MEM_OP_NOP, 32'h1234_5678, '0, 5'd7, 0, EXP_NONE, 0, 0);
            add_entry("nop_trap", 1, MEM_OP_NOP, 32'hcafe_0001, '0, 5'd8, 1, EXP_TRAP, 0, 0);
            add_entry("nop_odd_out", 1, MEM_OP_NOP, 32'h3, '0, 5'd9, 0, EXP_NONE, 0, 0);
            add_entry("ld_ovf", 1, MEM_OP_LDW, 32'h100, '0, 5'd10, 0, EXP_OVERFLOW, 0, 0);
            // Stall holds wb and blocks the store
            add_entry("stall_st", 1, MEM_OP_STW, 32'h100, d3, 5'd0, 1, EXP_NONE, 1, 0);
            add_entry("stall_ld", 1, MEM_OP_LDW, 32'h100, '0, 5'd11, 0, EXP_NONE, 1, 0);
            add_entry("ld_a_after_stall", 1, MEM_OP_LDW, 32'h100, '0, 5'd12, 0, EXP_NONE, 0, 0);
            // Flush gives the bubble and blocks the store
            add_entry("flush_st", 1, MEM_OP_STW, 32'h204, d3, 5'd0, 1, EXP_NONE, 0, 1);
            add_entry("ld_b_after_flush", 1, MEM_OP_LDW, 32'h204, '0, 5'd13, 0, EXP_NONE, 0, 0);
            add_entry("flush_stall", 1, MEM_OP_LDW, 32'h100, '0, 5'd14, 0, EXP_NONE, 1, 1);
            add_entry("stall_after_flush", 1, MEM_OP_NOP, 32'h55, '0, 5'd15, 0, EXP_EXT_INT, 1, 0);
            add_entry("invalid_ld", 0, MEM_OP_LDW, 32'h100, '0, 5'd16, 0, EXP_NONE, 0, 0);
            // LCG addresses and data, each store read back at once
            for (k = 0; k < 4; k++) begin
                ra = next_rand() & 32'hffff_fffc; // Word aligned
                rd = next_rand();
                add_entry("rnd_st", 1, MEM_OP_STW, ra, rd, 5'd0, 1, EXP_NONE, 0, 0);
                add_entry("rnd_ld", 1, MEM_OP_LDW, ra, '0, 5'd17, 0, EXP_NONE, 0, 0);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////
    task automatic check_wb(input string name, input mem_wb_t exp, input mem_wb_t act);
        if (act !== exp) begin
            wb_errors++;
            $display("error %s: wb expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            word_errors++;
            $display("error %s: fwd_data expected %h actual %h", name, exp, act);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin : main
        int i;
        int n;
        reset = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        ex    = '0;
        build_table();
        n          = tbl_ex.size();
        max_cycles = RESET_CYCLES + n + SLACK_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_wb("after_reset", bubble_wb(), wb);
        for (i = 0; i < n; i++) begin
            @(posedge clk);
            ex    <= tbl_ex[i];
            stall <= tbl_stall[i];
            flush <= tbl_flush[i];
            @(negedge clk);                       // Mid-cycle, all settled
            check_word(tbl_name[i], tbl_fwd[i], fwd_data);
            if (i > 0)
                check_wb(tbl_name[i-1], tbl_wb[i-1], wb);
        end
        @(posedge clk);
        ex    <= '0;                              // Idle after the last entry
        stall <= 1'b0;
        flush <= 1'b0;
        @(negedge clk);
        check_wb(tbl_name[n-1], tbl_wb[n-1], wb);
        $display("errors: wb %0d, fwd_data %0d, assertions %0d, total %0d",
                 wb_errors, word_errors, dut0.asserts0.assert_errors,
                 wb_errors + word_errors + dut0.asserts0.assert_errors);
        if (wb_errors + word_errors + dut0.asserts0.assert_errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== fmrt_mem.f ====
+incdir+.
fmrt_mem_pkg.sv
mem_ctrl.sv
bus_if.sv
spm.sv
mem_reg.sv
mem_stage.sv
mem_stage_asserts.sv
tb_mem_stage.sv
